//--- vlog.f
src/st_io_pkg.sv
src/st_sys_ctrl.sv
src/st_byte_fifo.sv
src/st_video_select.sv
src/st_io_bridge.sv
testbench/st_io_bridge_properties.sv
testbench/st_io_bridge_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the st i/o glue testbench with verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module st_io_bridge_tb \
	-f vlog.f \
	-o st_io_bridge_sim

./obj_dir/st_io_bridge_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^TESTBENCH PASSED$" sim.log; then
	exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

//--- testbench/st_io_bridge_tb.sv
// testbench for the st i/o glue top level; random stimulus checked against reference models
`timescale 1ns/1ps

module st_io_bridge_tb;

	import st_io_pkg::*;

	// phase lengths in cycles, drains included
	localparam int reset_cycles  = 10;
	localparam int ctrl_cycles   = 32;
	localparam int midi_cycles   = 420;
	localparam int par_cycles    = 40;
	localparam int flush_cycles  = 40;
	localparam int video_cycles  = 200;
	localparam int phase_total   = reset_cycles + ctrl_cycles + midi_cycles
		+ par_cycles + flush_cycles + video_cycles;
	localparam int timeout_limit = 2 * phase_total;

	logic               clk_32;
	logic               arst_n;
	logic               ctrl_wr;
	logic [ctrl_w-1:0]  ctrl_word;
	st_byte_wr_t        midi_wr;
	st_byte_wr_t        par_wr;
	logic               midi_rd_strobe;
	logic [byte_w-1:0]  midi_rd_data;
	logic               midi_available;
	logic               par_rd_strobe;
	logic [byte_w-1:0]  par_rd_data;
	logic               par_available;
	logic               par_busy;
	logic [1:0]         fdc_wp;
	logic [1:0]         scanlines;
	logic [1:0]         usb_redir;
	logic [joy_w-1:0]   joy2;
	st_video_t          shifter;
	st_video_t          viking;
	logic               viking_active;
	logic               blank_n;
	logic               monomode;
	st_video_t          video_out;
	logic               conf_ss_n;
	logic               fpga_ss_n;
	logic               user_sdo;
	logic               dio_sdo;
	wire                miso;

	// reference state
	logic [31:0]        rng = 32'h2d9d;
	logic [ctrl_w-1:0]  ctrl_m;            // control word as the dut should hold it
	logic [byte_w-1:0]  midi_q[$];
	logic [byte_w-1:0]  par_q[$];
	st_video_t          video_m;           // expected pixel after the next edge
	logic               wr_ok;
	logic               miso_z_exp;
	logic               miso_exp;
	int                 errors = 0;
	int                 checks = 0;
	int                 cycles = 0;

	st_io_bridge st_io_bridge_i (.*);

	initial begin
		clk_32 = 1'b0;
		forever #10 clk_32 = ~clk_32; // 20 ns
	end

	// run limit
	always @(posedge clk_32) begin
		cycles++;
		if (cycles > timeout_limit) begin
			$display("timeout: stimulus still running after %0d cycles", cycles);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// viking wins, else shifter with colours blanked unless mono
	function automatic st_video_t video_ref(input st_video_t sh, input st_video_t vk,
		input logic va, input logic bl_n, input logic mono);
		st_video_t v;
		if (va) begin
			v = vk;
		end else begin
			v = sh;
			if (!bl_n && !mono) v.rgb = '0; // syncs kept
		end
		return v;
	endfunction

	function automatic logic busy_ref(input logic [1:0] redir, input logic full,
		input logic [joy_w-1:0] joy);
		return (redir == redir_printer) ? full : joy[busy_joy_bit];
	endfunction

	task automatic check_equal(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic next_random(output logic [31:0] r);
		rng = xorshift32(rng);
		r = rng;
	endtask

	// one clock, then strobes cleared and background inputs randomized
	task automatic step();
		logic [31:0] a;
		logic [31:0] b;
		@(posedge clk_32);
		#2;
		ctrl_wr = 1'b0;
		midi_wr = '0;
		par_wr = '0;
		midi_rd_strobe = 1'b0;
		par_rd_strobe = 1'b0;
		next_random(a);
		next_random(b);
		shifter = a[13:0];
		viking = a[27:14];
		viking_active = a[28] & a[29]; // mostly shifter
		blank_n = a[30];
		monomode = b[20] & b[21];
		joy2 = b[15:0];
		conf_ss_n = b[16];
		fpga_ss_n = b[17];
		user_sdo = b[18];
		dio_sdo = b[19];
	endtask

	task automatic write_ctrl(input logic [ctrl_w-1:0] w);
		ctrl_wr = 1'b1;
		ctrl_word = w;
		step();
	endtask

	// pop until available drops
	task automatic drain_midi(output int n);
		n = 0;
		while (midi_available) begin
			midi_rd_strobe = 1'b1;
			n++;
			step();
		end
	endtask

	task automatic drain_par(output int n);
		n = 0;
		while (par_available) begin
			par_rd_strobe = 1'b1;
			n++;
			step();
		end
	endtask

	task automatic run_ctrl_phase();
		logic [31:0] r;
		repeat (16) begin
			next_random(r);
			write_ctrl(r & ~32'h1); // soft reset stays off
			step();
		end
	endtask

	task automatic run_midi_phase();
		logic [31:0] r;
		int n;
		repeat (400) begin
			next_random(r);
			midi_wr.strobe = r[0];
			midi_wr.data = r[15:8];
			midi_rd_strobe = r[1] && midi_available;
			step();
		end
		drain_midi(n);
	endtask

	task automatic run_par_phase();
		logic [31:0] r;
		int n;
		next_random(r);
		r[27:26] = redir_printer;
		r[0] = 1'b0;
		write_ctrl(r);
		step();
		for (int i = 0; i < 5; i++) begin
			next_random(r);
			par_wr.strobe = 1'b1;
			par_wr.data = r[7:0];
			step();
		end
		check_equal("par_busy", 32'(par_busy), 32'd1); // four held, fifth lost
		drain_par(n);
		check_equal("par_drained", 32'(n), 32'd4);
		r[27:26] = redir_none;
		r[0] = 1'b0; // fifos must keep data for the flush phase
		write_ctrl(r);
		repeat (20) step(); // busy now from joy2
	endtask

	task automatic run_flush_phase();
		logic [31:0] r;
		int n;
		for (int i = 0; i < 6; i++) begin
			next_random(r);
			midi_wr = {1'b1, r[7:0]};
			par_wr.strobe = (i < 3);
			par_wr.data = r[15:8];
			step();
		end
		next_random(r);
		write_ctrl(r | 32'h1);
		midi_wr.strobe = 1'b1; // lands on the flush edge
		midi_wr.data = r[23:16];
		step();
		check_equal("midi_available", 32'(midi_available), 32'd0);
		check_equal("par_available", 32'(par_available), 32'd0);
		write_ctrl(r & ~32'h1);
		step();
		for (int i = 0; i < 3; i++) begin
			next_random(r);
			midi_wr = {1'b1, r[7:0]};
			step();
		end
		drain_midi(n);
		check_equal("midi_drained", 32'(n), 32'd3);
	endtask

	// compare at the falling edge, then advance the models
	always @(negedge clk_32) begin
		if (!arst_n) begin
			ctrl_m = '0;
			midi_q.delete();
			par_q.delete();
			video_m = '0;
		end else begin
			check_equal("fdc_wp", 32'(fdc_wp), 32'(ctrl_m[7:6]));
			check_equal("scanlines", 32'(scanlines), 32'(ctrl_m[21:20]));
			check_equal("usb_redir", 32'(usb_redir), 32'(ctrl_m[27:26]));
			check_equal("par_busy", 32'(par_busy),
				32'(busy_ref(ctrl_m[27:26], par_q.size() == par_fifo_depth, joy2)));
			check_equal("midi_available", 32'(midi_available), 32'(midi_q.size() != 0));
			if (midi_q.size() != 0) begin
				check_equal("midi_rd_data", 32'(midi_rd_data), 32'(midi_q[0]));
			end
			check_equal("par_available", 32'(par_available), 32'(par_q.size() != 0));
			if (par_q.size() != 0) begin
				check_equal("par_rd_data", 32'(par_rd_data), 32'(par_q[0]));
			end
			check_equal("video_out", 32'(video_out), 32'(video_m));
			miso_z_exp = conf_ss_n && fpga_ss_n;
			miso_exp = !conf_ss_n ? user_sdo : dio_sdo; // user_io has priority
			check_equal("miso_is_z", 32'(miso === 1'bz), 32'(miso_z_exp));
			if (!miso_z_exp) begin
				check_equal("miso", 32'(miso), 32'(miso_exp));
			end
			if (ctrl_m[0]) begin
				midi_q.delete(); // soft reset
				par_q.delete();
			end else begin
				wr_ok = midi_wr.strobe && (midi_q.size() < midi_fifo_depth);
				if (midi_rd_strobe && midi_q.size() != 0) void'(midi_q.pop_front());
				if (wr_ok) midi_q.push_back(midi_wr.data);
				wr_ok = par_wr.strobe && (par_q.size() < par_fifo_depth);
				if (par_rd_strobe && par_q.size() != 0) void'(par_q.pop_front());
				if (wr_ok) par_q.push_back(par_wr.data);
			end
			if (ctrl_wr) ctrl_m = ctrl_word;
			video_m = video_ref(shifter, viking, viking_active, blank_n, monomode);
		end
	end

	initial begin
		arst_n = 1'b1;
		ctrl_wr = 1'b0;
		ctrl_word = '0;
		midi_wr = '0;
		par_wr = '0;
		midi_rd_strobe = 1'b0;
		par_rd_strobe = 1'b0;
		joy2 = '0;
		shifter = '0;
		viking = '0;
		viking_active = 1'b0;
		blank_n = 1'b0;
		monomode = 1'b0;
		conf_ss_n = 1'b1;
		fpga_ss_n = 1'b1;
		user_sdo = 1'b0;
		dio_sdo = 1'b0;
		#1;
		arst_n = 1'b0; // falling edge starts the reset
		repeat (reset_cycles) @(posedge clk_32);
		#2;
		arst_n = 1'b1;
		run_ctrl_phase();
		run_midi_phase();
		run_par_phase();
		run_flush_phase();
		repeat (video_cycles) step(); // video and miso from random background
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- testbench/st_io_bridge_properties.sv
// concurrent checks on fifo flags, soft reset and miso release, bound into the st i/o glue top level
`timescale 1ns/1ps

module st_io_bridge_properties (
	input logic clk_32,
	input logic arst_n,
	input logic soft_rst,
	input logic midi_wr_strobe,
	input logic par_wr_strobe,
	input logic midi_available,
	input logic par_available,
	input logic par_full,
	input logic conf_ss_n,
	input logic fpga_ss_n,
	input logic miso_is_z      // miso released
);

	// nothing stored while reset is held
	reset_flags_low: assert property (@(posedge clk_32)
		!arst_n |-> (!midi_available && !par_available && !par_full))
		else $error("fifo flags set during reset");

	// empty stays empty without a write
	midi_empty_holds: assert property (@(posedge clk_32) disable iff (!arst_n)
		(!midi_available && !midi_wr_strobe) |=> !midi_available)
		else $error("midi fifo shows data without a write");

	par_empty_holds: assert property (@(posedge clk_32) disable iff (!arst_n)
		(!par_available && !par_wr_strobe) |=> !par_available)
		else $error("printer fifo shows data without a write");

	// neither slave selected
	miso_released: assert property (@(posedge clk_32) disable iff (!arst_n)
		(conf_ss_n && fpga_ss_n) |-> miso_is_z)
		else $error("miso driven with both selects high");

	soft_rst_empties: assert property (@(posedge clk_32) disable iff (!arst_n)
		soft_rst |=> (!midi_available && !par_available))
		else $error("fifos not empty one cycle after soft reset");

endmodule

bind st_io_bridge st_io_bridge_properties st_io_bridge_properties_i (
	.clk_32         (clk_32),
	.arst_n         (arst_n),
	.soft_rst       (soft_rst),
	.midi_wr_strobe (midi_wr.strobe),
	.par_wr_strobe  (par_wr.strobe),
	.midi_available (midi_available),
	.par_available  (par_available),
	.par_full       (par_full),
	.conf_ss_n      (conf_ss_n),
	.fpga_ss_n      (fpga_ss_n),
	.miso_is_z      (miso === 1'bz)
);

//--- src/st_io_bridge.sv
// top level of the st i/o glue; control register, midi and printer fifos, video select and spi miso mux
`timescale 1ns/1ps

module st_io_bridge (
	// clock and reset
	input  logic                         clk_32,
	input  logic                         arst_n,
	// control word from the io controller
	input  logic                         ctrl_wr,
	input  logic [st_io_pkg::ctrl_w-1:0] ctrl_word,
	// st side byte writes
	input  st_io_pkg::st_byte_wr_t       midi_wr,        // acia data register
	input  st_io_pkg::st_byte_wr_t       par_wr,         // psg port b
	// io controller drain side
	input  logic                         midi_rd_strobe,
	output logic [st_io_pkg::byte_w-1:0] midi_rd_data,
	output logic                         midi_available,
	input  logic                         par_rd_strobe,
	output logic [st_io_pkg::byte_w-1:0] par_rd_data,
	output logic                         par_available,
	// decoded settings
	output logic                         par_busy,
	output logic [1:0]                   fdc_wp,
	output logic [1:0]                   scanlines,
	output logic [1:0]                   usb_redir,
	// extra joystick
	input  logic [st_io_pkg::joy_w-1:0]  joy2,
	// video
	input  st_io_pkg::st_video_t         shifter,
	input  st_io_pkg::st_video_t         viking,
	input  logic                         viking_active,
	input  logic                         blank_n,
	input  logic                         monomode,
	output st_io_pkg::st_video_t         video_out,
	// spi
	input  logic                         conf_ss_n,      // user_io select
	input  logic                         fpga_ss_n,      // data_io select
	input  logic                         user_sdo,
	input  logic                         dio_sdo,
	output wire                          miso
);

	import st_io_pkg::*;

	logic soft_rst;  // bit 0 of control word
	logic par_full;  // feeds printer busy

	// control register and decode
	st_sys_ctrl st_sys_ctrl_i (
		.clk_32    (clk_32),
		.arst_n    (arst_n),
		.ctrl_wr   (ctrl_wr),
		.ctrl_word (ctrl_word),
		.par_full  (par_full),
		.joy2      (joy2),
		.soft_rst  (soft_rst),
		.fdc_wp    (fdc_wp),
		.scanlines (scanlines),
		.usb_redir (usb_redir),
		.par_busy  (par_busy)
	);

	// midi out, filled by the acia, emptied by the io controller
	st_byte_fifo #(.depth(midi_fifo_depth)) midi_fifo (
		.clk_32         (clk_32),
		.arst_n         (arst_n),
		.flush          (soft_rst),
		.wr             (midi_wr),
		.rd_strobe      (midi_rd_strobe),
		.rd_data        (midi_rd_data),
		.data_available (midi_available),
		.full           ()               // midi has no flow control
	);

	// printer out
	st_byte_fifo #(.depth(par_fifo_depth)) par_fifo (
		.clk_32         (clk_32),
		.arst_n         (arst_n),
		.flush          (soft_rst),
		.wr             (par_wr),
		.rd_strobe      (par_rd_strobe),
		.rd_data        (par_rd_data),
		.data_available (par_available),
		.full           (par_full)
	);

	// video source
	st_video_select st_video_select_i (
		.clk_32        (clk_32),
		.arst_n        (arst_n),
		.shifter       (shifter),
		.viking        (viking),
		.viking_active (viking_active),
		.blank_n       (blank_n),
		.monomode      (monomode),
		.video_out     (video_out)
	);

	// user_io first, then data_io, else released so the line can be sniffed
	assign miso = !conf_ss_n ? user_sdo :
		(!fpga_ss_n ? dio_sdo : 1'bz);

endmodule

//--- src/st_video_select.sv
// video source mux; picks viking card or blanked shifter output and registers the pixel
`timescale 1ns/1ps

module st_video_select (
	input  logic                  clk_32,
	input  logic                  arst_n,
	input  st_io_pkg::st_video_t  shifter,       // st shifter pixel and syncs
	input  st_io_pkg::st_video_t  viking,        // viking card pixel and syncs
	input  logic                  viking_active,
	input  logic                  blank_n,       // shifter display enable
	input  logic                  monomode,      // mono monitor, no blanking
	output st_io_pkg::st_video_t  video_out
);

	import st_io_pkg::*;

	st_video_t sel;      // next pixel
	st_rgb_t   st_rgb;   // shifter colours after blanking

	// mono mode ignores blank_n, the monochrome timing has its own border
	always_comb begin
		if (blank_n || monomode) begin
			st_rgb = shifter.rgb;
		end else begin
			st_rgb = '0; // black outside the display window
		end
	end

	// viking overrides the whole frame
	always_comb begin
		if (viking_active) begin
			sel = viking;
		end else begin
			sel.rgb   = st_rgb;
			sel.hsync = shifter.hsync; // syncs never blanked
			sel.vsync = shifter.vsync;
		end
	end

	// one cycle latency
	always_ff @(posedge clk_32 or negedge arst_n) begin
		if (!arst_n) begin
			video_out <= '0;
		end else begin
			video_out <= sel;
		end
	end

endmodule

//--- src/st_byte_fifo.sv
// show-ahead byte fifo with write strobe and read strobe; used for midi out and printer out
`timescale 1ns/1ps

module st_byte_fifo #(
	parameter int depth = st_io_pkg::midi_fifo_depth
) (
	input  logic                         clk_32,
	input  logic                         arst_n,
	input  logic                         flush,          // soft reset
	input  st_io_pkg::st_byte_wr_t       wr,
	input  logic                         rd_strobe,      // pops the shown byte
	output logic [st_io_pkg::byte_w-1:0] rd_data,
	output logic                         data_available,
	output logic                         full
);

	import st_io_pkg::*;

	typedef logic [$clog2(depth)-1:0]   ptr_t; // ring index
	typedef logic [$clog2(depth+1)-1:0] cnt_t; // 0..depth

	logic [byte_w-1:0] mem [depth]; // storage
	ptr_t wr_ptr;
	ptr_t rd_ptr;
	cnt_t count;
	logic do_wr;
	logic do_rd;

	// writes to a full fifo are lost, reads of an empty one ignored
	assign do_wr = wr.strobe && !full;
	assign do_rd = rd_strobe && data_available;

	// payload
	always_ff @(posedge clk_32) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr.data;
		end
	end

	// pointers and occupancy
	always_ff @(posedge clk_32 or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			wr_ptr <= '0; // drop everything
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= (wr_ptr == ptr_t'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == ptr_t'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or none
			endcase
		end
	end

	// oldest byte always on the output
	assign rd_data        = mem[rd_ptr];
	assign data_available = (count != '0);
	assign full           = (count == cnt_t'(depth));

endmodule

//--- src/st_sys_ctrl.sv
// system control register; holds the io controller word and decodes settings and printer busy
`timescale 1ns/1ps

module st_sys_ctrl (
	input  logic                         clk_32,
	input  logic                         arst_n,
	input  logic                         ctrl_wr,   // one cycle strobe from io controller
	input  logic [st_io_pkg::ctrl_w-1:0] ctrl_word,
	input  logic                         par_full,  // parallel fifo full flag
	input  logic [st_io_pkg::joy_w-1:0]  joy2,
	output logic                         soft_rst,
	output logic [1:0]                   fdc_wp,
	output logic [1:0]                   scanlines,
	output logic [1:0]                   usb_redir,
	output logic                         par_busy
);

	import st_io_pkg::*;

	st_ctrl_word_u ctrl_q; // held control word

	// load raw view on strobe
	// everything reads zero after reset so soft reset is released
	always_ff @(posedge clk_32 or negedge arst_n) begin
		if (!arst_n) begin
			ctrl_q.raw <= '0;
		end else if (ctrl_wr) begin
			ctrl_q.raw <= ctrl_word; // visible one edge later
		end
	end

	// field view out
	assign soft_rst  = ctrl_q.f.soft_rst;  // held as long as bit 0 stays set
	assign fdc_wp    = ctrl_q.f.fdc_wp;
	assign scanlines = ctrl_q.f.scanlines; // goes to the scan doubler
	assign usb_redir = ctrl_q.f.usb_redir;

	// printer busy source
	// with printer redirection the io controller is the printer,
	// so busy means our fifo cannot take another byte
	// otherwise the line comes from the extra joystick port
	always_comb begin
		case (ctrl_q.f.usb_redir)
			redir_printer: par_busy = par_full;
			redir_none,
			redir_rs232,
			redir_midi:    par_busy = joy2[busy_joy_bit]; // pulled up if no adapter
		endcase
	end

endmodule

//--- src/st_io_pkg.sv
// shared widths, control word layout, redirection codes and port structs for the st i/o glue

package st_io_pkg;

	// data path widths
	localparam int byte_w  = 8;  // midi / printer byte
	localparam int color_w = 4;  // per colour channel, as the st shifter delivers
	localparam int ctrl_w  = 32; // system control word from the io controller
	localparam int joy_w   = 16; // extra joystick word

	// fifo depths
	localparam int midi_fifo_depth = 16;
	localparam int par_fifo_depth  = 4; // small on purpose, busy comes from its full flag

	// usb target port redirection, field bits 27:26 of the control word
	localparam logic [1:0] redir_none    = 2'd0;
	localparam logic [1:0] redir_rs232   = 2'd1;
	localparam logic [1:0] redir_printer = 2'd2;
	localparam logic [1:0] redir_midi    = 2'd3;

	// joystick 2 bit that doubles as printer busy (gauntlet adapter)
	localparam int busy_joy_bit = 4;

	// field view of the control word, msb first
	typedef struct packed {
		logic [3:0]  rsvd_31_28;
		logic [1:0]  usb_redir;  // bits 27:26
		logic [3:0]  rsvd_25_22;
		logic [1:0]  scanlines;  // bits 21:20
		logic [11:0] rsvd_19_8;
		logic [1:0]  fdc_wp;     // bits 7:6, one per drive
		logic [4:0]  rsvd_5_1;
		logic        soft_rst;   // bit 0
	} st_ctrl_fields_t;

	// same 32 bits, loaded raw and read back by field
	typedef union packed {
		logic [ctrl_w-1:0] raw;
		st_ctrl_fields_t   f;
	} st_ctrl_word_u;

	// one byte write from the st side
	typedef struct packed {
		logic              strobe; // single cycle
		logic [byte_w-1:0] data;
	} st_byte_wr_t;

	// colour triple
	typedef struct packed {
		logic [color_w-1:0] r;
		logic [color_w-1:0] g;
		logic [color_w-1:0] b;
	} st_rgb_t;

	// one video pixel with syncs
	typedef struct packed {
		st_rgb_t rgb;
		logic    hsync; // polarity as delivered by the source
		logic    vsync;
	} st_video_t;

endpackage
